// ==== hw/xaui_csr_pkg.sv ====
// xaui csr shared definitions

package xaui_csr_pkg;

    ////////////////////////////////////////////////////////////
    // bus and lane geometry
    ////////////////////////////////////////////////////////////

    // word address, byte offsets are not carried
    parameter int addr_width = 5;
    parameter int data_width = 32;
    parameter int lane_count = 4;

    // each status bank is one 16 bit word
    parameter int bank_width = 16;

    // digital reset register holds rx and tx reset
    parameter int reset_bits_width = 2;

    ////////////////////////////////////////////////////////////
    // defaults for module parameters
    ////////////////////////////////////////////////////////////

    parameter int status_banks_default = 4;
    parameter int sync_stages_default = 2;

    ////////////////////////////////////////////////////////////
    // register map, word indices
    ////////////////////////////////////////////////////////////

    parameter int reset_reg_index = 0;
    parameter int rx_cntrl_reg_index = 1;
    parameter int tx_cntrl_reg_index = 2;
    // status bank i lives at status_base_index + i
    parameter int status_base_index = 3;

    typedef logic [addr_width-1:0] word_addr_t;
    typedef logic [data_width-1:0] csr_word_t;
    typedef logic [lane_count-1:0] lane_mask_t;
    typedef logic [bank_width-1:0] bank_word_t;
    typedef logic [reset_bits_width-1:0] reset_bits_t;

endpackage

// ==== hw/csr_ctrl_if.sv ====
// csr control register link

`timescale 1ns/1ps

interface csr_ctrl_if;

    // index of the word currently on the bus
    xaui_csr_pkg::word_addr_t reg_index;
    // {rx_digitalreset, tx_digitalreset}
    xaui_csr_pkg::reset_bits_t reset_bits;
    // per lane polarity inversion
    xaui_csr_pkg::lane_mask_t rx_invpolarity;
    xaui_csr_pkg::lane_mask_t tx_invpolarity;

    // access decoder drives the link
    modport source (
        output reg_index, reset_bits, rx_invpolarity, tx_invpolarity
    );

    // read multiplexer only looks at it
    modport sink (
        input reg_index, reset_bits, rx_invpolarity, tx_invpolarity
    );

endinterface

// ==== hw/csr_access_ctrl.sv ====
// csr access decoder and control registers

`timescale 1ns/1ps

module csr_access_ctrl #(
    parameter int status_banks = xaui_csr_pkg::status_banks_default
) (
    input  logic                       clk,
    input  logic                       reset,
    input  xaui_csr_pkg::word_addr_t   address,
    input  logic                       read,
    input  logic                       write,
    input  xaui_csr_pkg::csr_word_t    writedata,
    csr_ctrl_if.source                 ctrl,
    output logic [status_banks-1:0]    read_clear,
    output logic                       r_rx_digitalreset,
    output logic                       r_tx_digitalreset,
    output xaui_csr_pkg::lane_mask_t   r_rx_invpolarity,
    output xaui_csr_pkg::lane_mask_t   r_tx_invpolarity
);

    ////////////////////////////////////////////////////////////
    // control registers
    ////////////////////////////////////////////////////////////

    // bit 1 rx digital reset, bit 0 tx digital reset
    xaui_csr_pkg::reset_bits_t reset_q;
    // polarity inversion, one bit per lane
    xaui_csr_pkg::lane_mask_t  rx_cntrl_q;
    xaui_csr_pkg::lane_mask_t  tx_cntrl_q;

    // write strobe lands at the edge closing the write cycle
    // status and unmapped indices fall through the case untouched
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reset_q    <= '0;
            rx_cntrl_q <= '0;
            tx_cntrl_q <= '0;
        end else if (write) begin
            case (address)
                xaui_csr_pkg::word_addr_t'(xaui_csr_pkg::reset_reg_index): begin
                    reset_q <= xaui_csr_pkg::reset_bits_t'(writedata);
                end
                xaui_csr_pkg::word_addr_t'(xaui_csr_pkg::rx_cntrl_reg_index): begin
                    rx_cntrl_q <= xaui_csr_pkg::lane_mask_t'(writedata);
                end
                xaui_csr_pkg::word_addr_t'(xaui_csr_pkg::tx_cntrl_reg_index): begin
                    tx_cntrl_q <= xaui_csr_pkg::lane_mask_t'(writedata);
                end
                default: begin
                    // read-only or unmapped, nothing to do
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // read-clear strobes
    ////////////////////////////////////////////////////////////

    // one strobe per bank, high for the whole read cycle
    // bank clears at the edge that ends the read
    always_comb begin
        for (int i = 0; i < status_banks; i++) begin
            read_clear[i] = read &&
                (address == xaui_csr_pkg::word_addr_t'(xaui_csr_pkg::status_base_index + i));
        end
    end

    ////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////

    // index goes straight through, read data is combinational
    assign ctrl.reg_index      = address;
    assign ctrl.reset_bits     = reset_q;
    assign ctrl.rx_invpolarity = rx_cntrl_q;
    assign ctrl.tx_invpolarity = tx_cntrl_q;

    // transceiver control pins
    assign r_rx_digitalreset = reset_q[1];
    assign r_tx_digitalreset = reset_q[0];
    assign r_rx_invpolarity  = rx_cntrl_q;
    assign r_tx_invpolarity  = tx_cntrl_q;

endmodule

// ==== hw/status_sticky_bank.sv ====
// sticky status bank

`timescale 1ns/1ps

module status_sticky_bank #(
    parameter int sync_stages = xaui_csr_pkg::sync_stages_default
) (
    input  logic                      clk,
    input  logic                      reset,
    input  xaui_csr_pkg::bank_word_t  status_raw,
    input  logic                      read_clear,
    output xaui_csr_pkg::bank_word_t  status_held
);

    ////////////////////////////////////////////////////////////
    // synchronizer chain
    ////////////////////////////////////////////////////////////

    // lane flags come from the transceiver clock domains
    // stage 0 samples the raw level, last stage feeds the sticky bits
    xaui_csr_pkg::bank_word_t sync_q [sync_stages];
    xaui_csr_pkg::bank_word_t status_sync;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < sync_stages; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= status_raw;
            for (int i = 1; i < sync_stages; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign status_sync = sync_q[sync_stages-1];

    ////////////////////////////////////////////////////////////
    // sticky bits
    ////////////////////////////////////////////////////////////

    //  s  r | next
    // ------+------
    //  0  0 | hold
    //  0  1 | 0
    //  1  x | 1
    //
    // so next = s | (q & ~r), an event in the read cycle survives
    xaui_csr_pkg::bank_word_t held_q;
    xaui_csr_pkg::bank_word_t held_keep;

    // old value is dropped as a whole when the bank is read
    assign held_keep = read_clear ? '0 : held_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            held_q <= '0;
        end else begin
            held_q <= status_sync | held_keep;
        end
    end

    // bits are not coherent across lanes, each one crosses on its own
    assign status_held = held_q;

endmodule

// ==== hw/csr_read_mux.sv ====
// csr read data multiplexer

`timescale 1ns/1ps

module csr_read_mux #(
    parameter int status_banks = xaui_csr_pkg::status_banks_default
) (
    csr_ctrl_if.sink                  ctrl,
    input  xaui_csr_pkg::bank_word_t  bank_values [status_banks],
    output xaui_csr_pkg::csr_word_t   readdata
);

    ////////////////////////////////////////////////////////////
    // read decode
    ////////////////////////////////////////////////////////////

    // purely combinational, data follows the address in the same cycle
    // every register is zero-extended to the bus width
    always_comb begin
        // unmapped indices read zero
        readdata = '0;

        case (ctrl.reg_index)
            xaui_csr_pkg::word_addr_t'(xaui_csr_pkg::reset_reg_index): begin
                readdata = xaui_csr_pkg::csr_word_t'(ctrl.reset_bits);
            end
            xaui_csr_pkg::word_addr_t'(xaui_csr_pkg::rx_cntrl_reg_index): begin
                readdata = xaui_csr_pkg::csr_word_t'(ctrl.rx_invpolarity);
            end
            xaui_csr_pkg::word_addr_t'(xaui_csr_pkg::tx_cntrl_reg_index): begin
                readdata = xaui_csr_pkg::csr_word_t'(ctrl.tx_invpolarity);
            end
            default: begin
                // status banks sit in a contiguous run after the controls
                for (int i = 0; i < status_banks; i++) begin
                    if (ctrl.reg_index ==
                        xaui_csr_pkg::word_addr_t'(xaui_csr_pkg::status_base_index + i)) begin
                        readdata = xaui_csr_pkg::csr_word_t'(bank_values[i]);
                    end
                end
            end
        endcase
    end

endmodule

// ==== hw/xaui_csr_top.sv ====
// xaui transceiver csr block

`timescale 1ns/1ps

module xaui_csr_top #(
    parameter int status_banks = xaui_csr_pkg::status_banks_default,
    parameter int sync_stages  = xaui_csr_pkg::sync_stages_default
) (
    input  logic                      clk,
    input  logic                      reset,

    // memory-mapped slave
    input  xaui_csr_pkg::word_addr_t  address,
    input  logic                      read,
    input  logic                      write,
    input  xaui_csr_pkg::csr_word_t   writedata,
    output xaui_csr_pkg::csr_word_t   readdata,

    // receive lane flags, two bits per lane
    input  logic [7:0]                rx_patterndetect,
    input  logic [7:0]                rx_syncstatus,
    input  logic [7:0]                rx_errdetect,
    input  logic [7:0]                rx_disperr,
    input  logic [7:0]                rx_rmfifodatainserted,
    input  logic [7:0]                rx_rmfifodatadeleted,

    // one bit per lane
    input  logic [3:0]                rx_phase_comp_fifo_error,
    input  logic [3:0]                rx_rlv,
    input  logic [3:0]                rx_rmfifofull,
    input  logic [3:0]                tx_phase_comp_fifo_error,

    // transceiver control
    output logic                      r_rx_digitalreset,
    output logic                      r_tx_digitalreset,
    output xaui_csr_pkg::lane_mask_t  r_rx_invpolarity,
    output xaui_csr_pkg::lane_mask_t  r_tx_invpolarity
);

    ////////////////////////////////////////////////////////////
    // bank packing
    ////////////////////////////////////////////////////////////

    // upper field first in every bank
    xaui_csr_pkg::bank_word_t bank_raw [xaui_csr_pkg::status_banks_default];
    xaui_csr_pkg::bank_word_t bank_values [status_banks];
    logic [status_banks-1:0]  read_clear;

    assign bank_raw[0] = {rx_patterndetect, rx_syncstatus};
    assign bank_raw[1] = {rx_errdetect, rx_disperr};
    assign bank_raw[2] = {rx_rmfifodatainserted, rx_rmfifodatadeleted};
    // the four single bit per lane flags share bank 3
    assign bank_raw[3] = {tx_phase_comp_fifo_error, rx_rmfifofull,
                          rx_rlv, rx_phase_comp_fifo_error};

    ////////////////////////////////////////////////////////////
    // bus decode and control registers
    ////////////////////////////////////////////////////////////

    csr_ctrl_if u_ctrl_if ();

    csr_access_ctrl #(
        .status_banks (status_banks)
    ) u_access_ctrl (
        .clk               (clk),
        .reset             (reset),
        .address           (address),
        .read              (read),
        .write             (write),
        .writedata         (writedata),
        .ctrl              (u_ctrl_if.source),
        .read_clear        (read_clear),
        .r_rx_digitalreset (r_rx_digitalreset),
        .r_tx_digitalreset (r_tx_digitalreset),
        .r_rx_invpolarity  (r_rx_invpolarity),
        .r_tx_invpolarity  (r_tx_invpolarity)
    );

    ////////////////////////////////////////////////////////////
    // status banks
    ////////////////////////////////////////////////////////////

    // identical banks, each with its own clear strobe
    for (genvar i = 0; i < status_banks; i++) begin : g_bank
        status_sticky_bank #(
            .sync_stages (sync_stages)
        ) u_bank (
            .clk         (clk),
            .reset       (reset),
            .status_raw  (bank_raw[i]),
            .read_clear  (read_clear[i]),
            .status_held (bank_values[i])
        );
    end

    ////////////////////////////////////////////////////////////
    // read path
    ////////////////////////////////////////////////////////////

    csr_read_mux #(
        .status_banks (status_banks)
    ) u_read_mux (
        .ctrl        (u_ctrl_if.sink),
        .bank_values (bank_values),
        .readdata    (readdata)
    );

endmodule

// ==== dv/xaui_csr_props.sv ====
// csr block assertions

`timescale 1ns/1ps

module xaui_csr_props #(
    parameter int status_banks = xaui_csr_pkg::status_banks_default
) (
    input logic                      clk,
    input logic                      reset,
    input xaui_csr_pkg::word_addr_t  address,
    input logic                      write,
    input xaui_csr_pkg::csr_word_t   readdata,
    input logic                      r_rx_digitalreset,
    input logic                      r_tx_digitalreset,
    input xaui_csr_pkg::lane_mask_t  r_rx_invpolarity,
    input xaui_csr_pkg::lane_mask_t  r_tx_invpolarity,
    input logic [status_banks-1:0]   read_clear,
    input xaui_csr_pkg::bank_word_t  bank_values [status_banks]
);

    ////////////////////////////////////////////////////////////
    // control outputs
    ////////////////////////////////////////////////////////////

    // all control pins in one vector
    logic [9:0] ctrl_pins;

    assign ctrl_pins = {r_rx_digitalreset, r_tx_digitalreset,
                        r_rx_invpolarity, r_tx_invpolarity};

    // no write strobe at the last edge, no change
    ctrl_hold: assert property (@(posedge clk) disable iff (reset)
        !$past(write) |-> $stable(ctrl_pins))
        else $error("control output moved without a write");

    // anything past the last bank is a hole in the map
    unmapped_zero: assert property (@(posedge clk) disable iff (reset)
        (address >= xaui_csr_pkg::status_base_index + status_banks) |-> (readdata == '0))
        else $error("unmapped index returned nonzero data");

    ////////////////////////////////////////////////////////////
    // sticky banks
    ////////////////////////////////////////////////////////////

    // a held bit may only drop at the edge that ends a read of its bank
    for (genvar i = 0; i < status_banks; i++) begin : g_sticky
        sticky_fall: assert property (@(posedge clk) disable iff (reset)
            !$past(read_clear[i]) |-> (($past(bank_values[i]) & ~bank_values[i]) == '0))
            else $error("status bank %0d lost a bit without a read", i);
    end

endmodule

bind xaui_csr_top xaui_csr_props #(
    .status_banks (status_banks)
) u_props (
    .clk               (clk),
    .reset             (reset),
    .address           (address),
    .write             (write),
    .readdata          (readdata),
    .r_rx_digitalreset (r_rx_digitalreset),
    .r_tx_digitalreset (r_tx_digitalreset),
    .r_rx_invpolarity  (r_rx_invpolarity),
    .r_tx_invpolarity  (r_tx_invpolarity),
    .read_clear        (read_clear),
    .bank_values       (bank_values)
);

// ==== dv/tb_clock_gen.sv ====
// testbench clock and reset

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int half_period  = 50,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic reset
);

    // free running 100 ns clock
    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // reset drops on a rising edge, like any other driven input
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== dv/tb_xaui_csr.sv ====
// xaui csr testbench

`timescale 1ns/1ps

module tb_xaui_csr;

    localparam int status_banks = xaui_csr_pkg::status_banks_default;
    localparam int sync_stages  = xaui_csr_pkg::sync_stages_default;
    localparam int bank_base    = xaui_csr_pkg::status_base_index;
    localparam int reset_limit  = 20;

    logic clk, reset, read, write;
    logic [4:0] address;
    logic [31:0] writedata, readdata;
    logic [7:0] rx_patterndetect, rx_syncstatus, rx_errdetect, rx_disperr;
    logic [7:0] rx_rmfifodatainserted, rx_rmfifodatadeleted;
    logic [3:0] rx_phase_comp_fifo_error, rx_rlv, rx_rmfifofull, tx_phase_comp_fifo_error;
    logic r_rx_digitalreset, r_tx_digitalreset;
    logic [3:0] r_rx_invpolarity, r_tx_invpolarity;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // {rx reset, tx reset} and the per lane polarity words
    logic [1:0] model_reset;
    logic [3:0] model_rx, model_tx;
    // events seen since the last read of each bank
    logic [15:0] model_bank [status_banks];
    // flag words currently driven, one per bank
    logic [15:0] cur_flags [status_banks];
    integer seed = 32'hca690146;
    int error_count = 0;
    int test_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    tb_clock_gen u_clock_gen (.clk(clk), .reset(reset));

    xaui_csr_top #(
        .status_banks (status_banks),
        .sync_stages  (sync_stages)
    ) u_xaui_csr_top (.*);

    // expected read data straight from the register map
    function automatic logic [31:0] expected_read(input int idx);
        if (idx == 0) return {30'd0, model_reset};
        if (idx == 1 || idx == 2) return {28'd0, (idx == 1) ? model_rx : model_tx};
        if (idx >= bank_base && idx < bank_base + status_banks)
            return {16'd0, model_bank[idx - bank_base]};
        return '0;
    endfunction

    task automatic write_reg(input int idx, input logic [31:0] data);
        @(posedge clk);
        address <= idx[4:0];
        write <= 1'b1;
        writedata <= data;
        @(posedge clk);
        write <= 1'b0;
        // only the three control words take writes
        if (idx == 0) model_reset = data[1:0];
        if (idx == 1) model_rx = data[3:0];
        if (idx == 2) model_tx = data[3:0];
    endtask

    task automatic read_index(input int idx);
        logic [31:0] expected;
        logic [31:0] got;
        expected = expected_read(idx);
        @(posedge clk);
        address <= idx[4:0];
        read <= 1'b1;
        @(negedge clk);
        got = readdata;
        @(posedge clk);
        read <= 1'b0;
        if (got !== expected) begin
            $display("Fail at %0t: index %0d read %h, expected %h", $time, idx, got, expected);
            error_count++;
        end
        // a read empties the bank except for flags still high
        if (idx >= bank_base && idx < bank_base + status_banks)
            model_bank[idx - bank_base] = cur_flags[idx - bank_base];
    endtask

    task automatic check_controls();
        @(negedge clk);
        if ({r_rx_digitalreset, r_tx_digitalreset} !== model_reset ||
            r_rx_invpolarity !== model_rx || r_tx_invpolarity !== model_tx) begin
            $display("Fail at %0t: control outputs %b %b %h %h, expected %b %h %h", $time,
                     r_rx_digitalreset, r_tx_digitalreset, r_rx_invpolarity,
                     r_tx_invpolarity, model_reset, model_rx, model_tx);
            error_count++;
        end
    endtask

    // spread cur_flags over the lane ports with the upper field first
    task automatic apply_flags();
        @(posedge clk);
        {rx_patterndetect, rx_syncstatus} <= cur_flags[0];
        {rx_errdetect, rx_disperr} <= cur_flags[1];
        {rx_rmfifodatainserted, rx_rmfifodatadeleted} <= cur_flags[2];
        {tx_phase_comp_fifo_error, rx_rmfifofull, rx_rlv, rx_phase_comp_fifo_error}
            <= cur_flags[3];
        for (int b = 0; b < status_banks; b++) model_bank[b] |= cur_flags[b];
    endtask

    // sparse random pulses followed by quiet inputs and time for the synchronizers
    task automatic pulse_flags(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            for (int b = 0; b < status_banks; b++)
                cur_flags[b] = $random(seed) & $random(seed) & $random(seed);
            apply_flags();
        end
        for (int b = 0; b < status_banks; b++) cur_flags[b] = '0;
        apply_flags();
        repeat (sync_stages + 1) @(posedge clk);
    endtask

    task automatic end_test(input string name);
        if (error_count == test_errors) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    initial begin
        int cycles;
        int pick;
        int bit_pos;
        {read, write, address, writedata} = '0;
        {rx_patterndetect, rx_syncstatus, rx_errdetect, rx_disperr} = '0;
        {rx_rmfifodatainserted, rx_rmfifodatadeleted} = '0;
        {rx_phase_comp_fifo_error, rx_rlv, rx_rmfifofull, tx_phase_comp_fifo_error} = '0;
        {model_reset, model_rx, model_tx} = '0;
        for (int b = 0; b < status_banks; b++) {model_bank[b], cur_flags[b]} = '0;
        cycles = 0;
        while (reset !== 1'b0 && cycles < reset_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            $display("timeout: reset still high after %0d cycles", reset_limit);
            $display("TEST FAIL");
            $finish;
        end else begin
            check_controls();
            for (int i = 0; i < bank_base + status_banks; i++) read_index(i);
            end_test("after_reset");
            for (int n = 0; n < 8; n++) begin
                pick = $unsigned($random(seed)) % 3;
                write_reg(pick, $random(seed));
                check_controls();
                read_index(pick);
            end
            end_test("control_registers");
            pulse_flags(6);
            for (int b = 0; b < status_banks; b++) read_index(bank_base + b);
            end_test("sticky_capture");
            // second read of bank 0 comes back empty while the rest still hold
            pulse_flags(4);
            read_index(bank_base);
            read_index(bank_base);
            for (int b = 1; b < status_banks; b++) read_index(bank_base + b);
            end_test("clear_on_read");
            pick = $unsigned($random(seed)) % status_banks;
            bit_pos = $unsigned($random(seed)) % 16;
            cur_flags[pick] = 16'd1 << bit_pos;
            apply_flags();
            repeat (sync_stages + 1) @(posedge clk);
            read_index(bank_base + pick);
            read_index(bank_base + pick);
            // drop the flag so that its last synchronized sample meets the next read edge
            cur_flags[pick] = '0;
            apply_flags();
            repeat (sync_stages - 2) @(posedge clk);
            read_index(bank_base + pick);
            // that edge saw the event together with the clear, so the bit stays
            model_bank[pick] = 16'd1 << bit_pos;
            read_index(bank_base + pick);
            read_index(bank_base + pick);
            end_test("set_wins_over_clear");
            for (int i = bank_base + status_banks; i < 32; i++) read_index(i);
            for (int n = 0; n < 8; n++) begin
                write_reg(bank_base + $unsigned($random(seed)) % (32 - bank_base), $random(seed));
                check_controls();
            end
            for (int i = 0; i < bank_base + status_banks; i++) read_index(i);
            end_test("unmapped_and_read_only");
            $display("tests: %0d passed, %0d failed, %0d errors", tests_passed,
                     tests_failed, error_count);
            if (error_count == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== all.f ====
hw/xaui_csr_pkg.sv
hw/csr_ctrl_if.sv
hw/csr_access_ctrl.sv
hw/status_sticky_bank.sv
hw/csr_read_mux.sv
hw/xaui_csr_top.sv
dv/xaui_csr_props.sv
dv/tb_clock_gen.sv
dv/tb_xaui_csr.sv
